// File: filelist.f
+incdir+.
jtag_pkg.sv
lights_pkg.sv
tap_decoder.sv
line_decoder.sv
instruction_buffer.sv
light_display.sv
tap_encoder.sv
user_logic.sv
user_logic_checker.sv
tb_clock_gen.sv
user_logic_tb.sv

// File: Bender.yml
package:
  name: user_logic

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - jtag_pkg.sv
      - lights_pkg.sv
      - tap_decoder.sv
      - line_decoder.sv
      - instruction_buffer.sv
      - light_display.sv
      - tap_encoder.sv
      - user_logic.sv
  - target: test
    include_dirs:
      - .
    files:
      - user_logic_checker.sv
      - tb_clock_gen.sv
      - user_logic_tb.sv

// File: user_logic_tb.sv
`default_nettype none
`include "user_logic_settings.svh"

module user_logic_tb import jtag_pkg::*, lights_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int grid = `LIGHT_GRID_SIZE;
    localparam int max_polls = 20;
    localparam int scan_cycles = 30;
    localparam int max_line_bytes = 32;
    localparam int total_lines = 93;
    localparam int n_reads = 8;
    // Twice the worst case of all sends, polls and resets
    localparam int cycle_limit = 2 * (total_lines * max_line_bytes * 8
        + n_reads * (max_polls * scan_cycles + 20));

    logic          conf_clk;
    logic          tck;
    logic          tdi;
    logic          tdo;
    tap_state_t    tap;
    int            seed;
    int            checks = 0;
    int            errors = 0;
    int            cycles = 0;
    int            start;
    inbound_byte_t file_q [$];
    logic [grid-1:0] model_grid [grid];

    tb_clock_gen u_clock_gen (
        .conf_clk (conf_clk),
        .tck      (tck)
    );

    user_logic uut (
        .tck      (tck),
        .tdi      (tdi),
        .conf_clk (conf_clk),
        .tap      (tap),
        .tdo      (tdo)
    );

    always @(posedge tck) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run still busy after %0d tck cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic int total_errors();
        return errors + uut.u_checker.failures;
    endfunction

    function automatic int rand_coord();
        return ($random(seed) & 32'h7fff_ffff) % grid;
    endfunction

    task automatic model_clear();
        for (int y = 0; y < grid; y++) begin
            model_grid[y] = '0;
        end
    endtask

    task automatic model_apply(input light_op_t op, input int x0, input int y0,
                               input int x1, input int y1);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                case (op)
                    turn_on:  model_grid[y][x] = 1'b1;
                    turn_off: model_grid[y][x] = 1'b0;
                    toggle:   model_grid[y][x] = ~model_grid[y][x];
                    default:  ;
                endcase
            end
        end
    endtask

    function automatic result_t model_count();
        result_t total;
        total = '0;
        for (int y = 0; y < grid; y++) begin
            for (int x = 0; x < grid; x++) begin
                total += model_grid[y][x];
            end
        end
        return total;
    endfunction

    task automatic add_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            file_q.push_back(text[i]);
        end
    endtask

    task automatic add_line(input light_op_t op, input int x0, input int y0,
                            input int x1, input int y1);
        string name;
        case (op)
            turn_on:  name = "turn on";
            turn_off: name = "turn off";
            default:  name = "toggle";
        endcase
        add_text($sformatf("%s %0d,%0d through %0d,%0d\n", name, x0, y0, x1, y1));
        // Lines outside these rules are skipped by the DUT
        if (x0 <= x1 && y0 <= y1 && x1 < grid && y1 < grid) begin
            model_apply(op, x0, y0, x1, y1);
        end
    endtask

    task automatic add_random_line();
        int a;
        int b;
        int c;
        int d;
        light_op_t op;
        a = rand_coord();
        b = rand_coord();
        c = rand_coord();
        d = rand_coord();
        op = light_op_t'(1 + (($random(seed) & 32'h7fff_ffff) % 3));
        add_line(op, (a < c) ? a : c, (b < d) ? b : d, (a < c) ? c : a, (b < d) ? d : b);
    endtask

    task automatic apply_reset();
        @(posedge tck);
        #10;
        tap.test_logic_reset = 1'b1;
        tap.ir_is_user = 1'b0;
        repeat (4) @(posedge tck);
        #10;
        tap.test_logic_reset = 1'b0;
        tap.ir_is_user = 1'b1;
    endtask

    // One DR scan: bypass bit, then every queued byte LSB first
    task automatic send_file();
        @(posedge tck);
        #10;
        tap.capture_dr = 1'b1;
        @(posedge tck);
        #10;
        tap.capture_dr = 1'b0;
        tap.shift_dr = 1'b1;
        tdi = 1'b0;
        @(posedge tck);
        #10;
        foreach (file_q[i]) begin
            for (int b = 0; b < 8; b++) begin
                tdi = file_q[i][b];
                @(posedge tck);
                #10;
            end
        end
        tap.shift_dr = 1'b0;
        tdi = 1'b0;
        tap.update_dr = 1'b1;
        @(posedge tck);
        #10;
        tap.update_dr = 1'b0;
        file_q.delete();
    endtask

    task automatic scan_result(output logic done, output result_t count);
        logic [24:0] bits;
        @(posedge tck);
        #10;
        tap.capture_dr = 1'b1;
        @(posedge tck);
        #10;
        tap.capture_dr = 1'b0;
        tap.shift_dr = 1'b1;
        for (int i = 0; i < 25; i++) begin
            bits[i] = tdo;
            @(posedge tck);
            #10;
        end
        tap.shift_dr = 1'b0;
        tap.update_dr = 1'b1;
        @(posedge tck);
        #10;
        tap.update_dr = 1'b0;
        done = bits[0];
        count = bits[24:1];
    endtask

    task automatic check_idle();
        logic done;
        result_t count;
        scan_result(done, count);
        checks += 2;
        assert (done == 1'b0) else begin
            $display("[ERROR] %0t done: got %0b, expected 0", $time, done);
            errors++;
        end
        assert (count == '0) else begin
            $display("[ERROR] %0t count: got %0d, expected 0", $time, count);
            errors++;
        end
    endtask

    task automatic check_count(input result_t expected);
        logic done;
        result_t count;
        done = 1'b0;
        for (int p = 0; p < max_polls && !done; p++) begin
            scan_result(done, count);
        end
        checks += 2;
        assert (done) else begin
            $display("Done bit still 0 after %0d result scans", max_polls);
            errors++;
        end
        assert (count == expected) else begin
            $display("[ERROR] %0t count: got %0d, expected %0d", $time, count, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (total_errors() == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, total_errors() - errors_before);
        end
    endtask

    initial begin
        seed = 58612;
        tdi = 1'b0;
        tap = '0;
        tap.test_logic_reset = 1'b1;
        apply_reset();

        start = total_errors();
        check_idle();
        report_test("test 1 idle after reset", start);

        start = total_errors();
        model_clear();
        add_line(turn_on, 0, 0, 3, 3);
        file_q.push_back(8'h04);
        send_file();
        check_count(24'd16);
        // Engine stays done, so a later file waits in the FIFO
        add_line(toggle, 0, 0, 3, 3);
        file_q.push_back(8'h04);
        send_file();
        check_count(24'd16);
        report_test("test 2 single square", start);

        start = total_errors();
        apply_reset();
        model_clear();
        repeat (20) add_random_line();
        file_q.push_back(8'h04);
        send_file();
        check_count(model_count());
        report_test("test 3 random rectangles", start);

        start = total_errors();
        apply_reset();
        model_clear();
        add_line(turn_on, 0, 0, 15, 15);
        add_text("turn on 1,2 through 3\n");
        add_line(toggle, 5, 5, 2, 2);
        add_line(turn_off, 0, 0, 16, 3);
        add_text("flip 1,1 through 2,2\n");
        add_line(toggle, 2, 2, 9, 4);
        file_q.push_back(8'h04);
        send_file();
        check_count(model_count());
        report_test("test 4 malformed lines", start);

        start = total_errors();
        apply_reset();
        check_idle();
        model_clear();
        repeat (5) add_random_line();
        file_q.push_back(8'h04);
        send_file();
        check_count(model_count());
        report_test("test 5 reset between runs", start);

        start = total_errors();
        apply_reset();
        model_clear();
        repeat (60) add_random_line();
        file_q.push_back(8'h04);
        send_file();
        check_count(model_count());
        report_test("test 6 long file", start);

        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, uut.u_checker.failures);
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic conf_clk,
    output logic tck
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        conf_clk = 1'b0;
        forever #50 conf_clk = ~conf_clk;
    end

    // 300 ns period, offset so its edges never meet the fast clock's
    initial begin
        tck = 1'b0;
        #20;
        forever #150 tck = ~tck;
    end

endmodule

`default_nettype wire

// File: user_logic_checker.sv
`default_nettype none

module user_logic_checker import lights_pkg::*; (
    input wire logic         conf_clk,
    input wire logic         tck,
    input wire logic         reset_tck,
    input wire logic         reset_cclk,
    input wire logic         count_done,
    input wire logic         instr_valid,
    input wire logic         fifo_full,
    input wire logic         fifo_valid,
    input wire logic         fifo_ready,
    input wire light_instr_t fifo_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // Done is a level that only reset clears
    done_held: assert property (@(posedge conf_clk) disable iff (reset_cclk)
        !$fell(count_done))
    else begin
        $error("count_done fell while reset was low");
        failures++;
    end

    // The line parser has no back-pressure
    no_write_when_full: assert property (@(posedge tck) disable iff (reset_tck)
        !(instr_valid && fifo_full))
    else begin
        $error("instruction written while the FIFO was full");
        failures++;
    end

    read_data_held: assert property (@(posedge conf_clk) disable iff (reset_cclk)
        (fifo_valid && !fifo_ready) |=> $stable(fifo_data))
    else begin
        $error("FIFO read data changed while valid was high and ready low");
        failures++;
    end

endmodule

bind user_logic user_logic_checker u_checker (
    .conf_clk    (conf_clk),
    .tck         (tck),
    .reset_tck   (reset_tck),
    .reset_cclk  (reset_cclk),
    .count_done  (count_done),
    .instr_valid (instr_valid),
    .fifo_full   (u_instruction_buffer.full),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .fifo_data   (fifo_data)
);

`default_nettype wire

// File: user_logic.sv
`default_nettype none
`include "user_logic_settings.svh"

module user_logic import jtag_pkg::*, lights_pkg::*; (
    input  wire logic       tck,
    input  wire logic       tdi,
    input  wire logic       conf_clk,
    input  wire tap_state_t tap,
    output logic            tdo
);

    localparam int stages = `CDC_SYNC_STAGES;

    logic              reset_tck;
    logic              reset_cclk;
    logic [stages-1:0] reset_pipe = '1;
    logic [stages-1:0] done_pipe;
    logic              done_tck;
    logic              byte_valid;
    inbound_byte_t     byte_data;
    logic              instr_valid;
    light_instr_t      instr;
    logic              fifo_valid;
    logic              fifo_ready;
    light_instr_t      fifo_data;
    logic              count_done;
    result_t           count_value;

    // Any non-user instruction holds the design in reset
    assign reset_tck = tap.test_logic_reset || !tap.ir_is_user;

    // Powers up asserted
    always_ff @(posedge conf_clk) begin
        reset_pipe <= {reset_pipe[stages-2:0], reset_tck};
    end
    assign reset_cclk = reset_pipe[stages-1];

    always_ff @(posedge tck) begin
        if (reset_tck) begin
            done_pipe <= '0;
        end else begin
            done_pipe <= {done_pipe[stages-2:0], count_done};
        end
    end
    assign done_tck = done_pipe[stages-1];

    tap_decoder u_tap_decoder (
        .tck        (tck),
        .tap        (tap),
        .tdi        (tdi),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    line_decoder u_line_decoder (
        .tck         (tck),
        .reset       (reset_tck),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    instruction_buffer u_instruction_buffer (
        .wr_clk   (tck),
        .wr_reset (reset_tck),
        .wr_valid (instr_valid),
        .wr_data  (instr),
        .rd_clk   (conf_clk),
        .rd_reset (reset_cclk),
        .rd_ready (fifo_ready),
        .rd_valid (fifo_valid),
        .rd_data  (fifo_data)
    );

    light_display u_light_display (
        .conf_clk    (conf_clk),
        .reset       (reset_cclk),
        .instr_ready (fifo_ready),
        .instr_valid (fifo_valid),
        .instr       (fifo_data),
        .count_done  (count_done),
        .count_value (count_value)
    );

    // Count is stable once done is seen, so it crosses as is
    tap_encoder u_tap_encoder (
        .tck   (tck),
        .tap   (tap),
        .done  (done_tck),
        .count (count_value),
        .tdo   (tdo)
    );

endmodule

`default_nettype wire

// File: tap_encoder.sv
`default_nettype none

module tap_encoder import jtag_pkg::*, lights_pkg::*; (
    input  wire logic       tck,
    input  wire tap_state_t tap,
    input  wire logic       done,
    input  wire result_t    count,
    output logic            tdo
);

    localparam int width = $bits(result_t) + 1;

    logic             reset;
    logic [width-1:0] shift_reg;

    assign reset = tap.test_logic_reset || !tap.ir_is_user;

    // Done sits in bit 0 so it leaves first
    always_ff @(posedge tck) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (tap.capture_dr) begin
            shift_reg <= {count, done};
        end else if (tap.shift_dr) begin
            shift_reg <= {1'b0, shift_reg[width-1:1]};
        end
    end

    assign tdo = shift_reg[0];

endmodule

`default_nettype wire

// File: light_display.sv
`default_nettype none
`include "user_logic_settings.svh"

module light_display import lights_pkg::*; (
    input  wire logic         conf_clk,
    input  wire logic         reset,
    output logic              instr_ready,
    input  wire logic         instr_valid,
    input  wire light_instr_t instr,
    output logic              count_done,
    output result_t           count_value
);

    localparam int n = `LIGHT_GRID_SIZE;
    localparam int rw = $clog2(n);

    typedef enum logic [2:0] {st_clear, st_idle, st_apply, st_count, st_done} state_t;

    state_t        state;
    logic [rw-1:0] row;
    logic [rw-1:0] row_sel;
    logic [rw-1:0] row_last;
    light_instr_t  cur;
    light_instr_t  act;
    logic [n-1:0]  grid [n];
    logic [n-1:0]  mask;
    logic          accept;
    logic          active_op;
    logic          write_row;

    assign instr_ready = state == st_idle;
    assign accept = instr_valid && instr_ready;
    assign count_done = state == st_done;

    // First row is written in the accept cycle straight from the input
    assign act = instr_ready ? instr : cur;
    assign active_op = (act.op != noop) && !act.malformed;
    assign row_sel = instr_ready ? act.y0[rw-1:0] : row;
    assign row_last = act.y1[rw-1:0];
    assign write_row = (accept || state == st_apply) && active_op;

    // Columns x0..x1
    always_comb begin
        for (int i = 0; i < n; i++) begin
            mask[i] = (coord_t'(i) >= act.x0) && (coord_t'(i) <= act.x1);
        end
    end

    always_ff @(posedge conf_clk) begin
        if (state == st_clear) begin
            grid[row] <= '0;
        end else if (write_row) begin
            case (act.op)
                turn_on:  grid[row_sel] <= grid[row_sel] | mask;
                turn_off: grid[row_sel] <= grid[row_sel] & ~mask;
                toggle:   grid[row_sel] <= grid[row_sel] ^ mask;
                default:  grid[row_sel] <= grid[row_sel];
            endcase
        end
    end

    always_ff @(posedge conf_clk) begin
        if (accept) begin
            cur <= instr;
        end
    end

    always_ff @(posedge conf_clk) begin
        if (reset) begin
            state <= st_clear;
            row <= '0;
            count_value <= '0;
        end else begin
            case (state)
                st_clear: begin
                    row <= (row == rw'(n - 1)) ? '0 : row + 1'b1;
                    if (row == rw'(n - 1)) state <= st_idle;
                end
                st_idle: begin
                    if (accept && active_op && row_sel != row_last) begin
                        row <= row_sel + 1'b1;
                        state <= st_apply;
                    end else if (accept && instr.last) begin
                        row <= '0;
                        state <= st_count;
                    end
                end
                st_apply: begin
                    row <= (row == row_last) ? '0 : row + 1'b1;
                    if (row == row_last) state <= cur.last ? st_count : st_idle;
                end
                st_count: begin
                    // One row's population per cycle
                    count_value <= count_value + result_t'($countones(grid[row]));
                    row <= row + 1'b1;
                    if (row == rw'(n - 1)) state <= st_done;
                end
                default: state <= st_done;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: instruction_buffer.sv
`default_nettype none
`include "user_logic_settings.svh"

module instruction_buffer import lights_pkg::*; (
    input  wire logic         wr_clk,
    input  wire logic         wr_reset,
    input  wire logic         wr_valid,
    input  wire light_instr_t wr_data,
    input  wire logic         rd_clk,
    input  wire logic         rd_reset,
    input  wire logic         rd_ready,
    output logic              rd_valid,
    output light_instr_t      rd_data
);

    localparam int depth = `INSTR_FIFO_DEPTH;
    localparam int aw = $clog2(depth);
    localparam int stages = `CDC_SYNC_STAGES;

    light_instr_t            mem [depth];
    logic [aw:0]             wr_bin;
    logic [aw:0]             wr_bin_next;
    logic [aw:0]             wr_gray;
    logic [aw:0]             rd_bin;
    logic [aw:0]             rd_bin_next;
    logic [aw:0]             rd_gray;
    logic [stages-1:0][aw:0] rd_gray_pipe;
    logic [stages-1:0][aw:0] wr_gray_pipe;
    logic [aw:0]             rd_gray_wclk;
    logic [aw:0]             wr_gray_rclk;
    logic                    full;
    logic                    push;
    logic                    pop;

    // Write side in tck
    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_gray_wclk = rd_gray_pipe[stages-1];
    assign full = wr_gray == {~rd_gray_wclk[aw:aw-1], rd_gray_wclk[aw-2:0]};
    assign push = wr_valid && !full;

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            wr_bin <= '0;
            wr_gray <= '0;
            rd_gray_pipe <= '0;
        end else begin
            rd_gray_pipe <= {rd_gray_pipe[stages-2:0], rd_gray};
            if (push) begin
                wr_bin <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_bin[aw-1:0]] <= wr_data;
        end
    end

    // Read side in conf_clk
    assign rd_bin_next = rd_bin + 1'b1;
    assign wr_gray_rclk = wr_gray_pipe[stages-1];
    assign rd_valid = rd_gray != wr_gray_rclk;
    assign rd_data = mem[rd_bin[aw-1:0]];
    assign pop = rd_valid && rd_ready;

    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            rd_bin <= '0;
            rd_gray <= '0;
            wr_gray_pipe <= '0;
        end else begin
            wr_gray_pipe <= {wr_gray_pipe[stages-2:0], wr_gray};
            if (pop) begin
                rd_bin <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: line_decoder.sv
`default_nettype none
`include "user_logic_settings.svh"

module line_decoder import jtag_pkg::*, lights_pkg::*; (
    input  wire logic          tck,
    input  wire logic          reset,
    input  wire logic          byte_valid,
    input  wire inbound_byte_t byte_data,
    output logic               instr_valid,
    output light_instr_t       instr
);

    logic          is_digit;
    logic          is_end;
    logic          op_seen;
    logic          in_num;
    light_op_t     op;
    inbound_byte_t prev_byte;
    coord_t        acc;
    logic [2:0]    num_count;
    logic [2:0]    cnt_next;
    coord_t        coords [4];
    coord_t        coord_next [4];
    logic          bad_range;

    assign is_digit = (byte_data >= "0") && (byte_data <= "9");
    assign is_end = (byte_data == 8'h0a) || (byte_data == 8'h04);

    // A number closes on the first non-digit
    always_comb begin
        coord_next = coords;
        cnt_next = num_count;
        if (in_num && !is_digit) begin
            if (num_count < 3'd4) begin
                coord_next[num_count[1:0]] = acc;
            end
            if (num_count < 3'd5) begin
                cnt_next = num_count + 3'd1;
            end
        end
    end

    // Order is x0, y0, x1, y1
    always_comb begin
        bad_range = (coord_next[0] > coord_next[2]) || (coord_next[1] > coord_next[3]);
        for (int i = 0; i < 4; i++) begin
            if (coord_next[i] >= coord_t'(`LIGHT_GRID_SIZE)) begin
                bad_range = 1'b1;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (reset) begin
            instr_valid <= 1'b0;
            op_seen <= 1'b0;
            op <= noop;
            in_num <= 1'b0;
            acc <= '0;
            num_count <= '0;
            prev_byte <= '0;
        end else begin
            instr_valid <= byte_valid && is_end;
            if (byte_valid && is_end) begin
                op_seen <= 1'b0;
                op <= noop;
                in_num <= 1'b0;
                acc <= '0;
                num_count <= '0;
                prev_byte <= '0;
            end else if (byte_valid) begin
                prev_byte <= byte_data;
                // First distinguishing letter picks the opcode
                if (!op_seen && prev_byte == "o" && byte_data == "n") begin
                    op <= turn_on;
                    op_seen <= 1'b1;
                end else if (!op_seen && prev_byte == "o" && byte_data == "f") begin
                    op <= turn_off;
                    op_seen <= 1'b1;
                end else if (!op_seen && prev_byte == "o" && byte_data == "g") begin
                    op <= toggle;
                    op_seen <= 1'b1;
                end
                if (is_digit) begin
                    in_num <= 1'b1;
                    // Saturate so a long number still reads as out of range
                    acc <= (acc > 12'd408) ? '1 : acc * coord_t'(10) + coord_t'(byte_data[3:0]);
                end else begin
                    in_num <= 1'b0;
                    acc <= '0;
                    num_count <= cnt_next;
                end
            end
        end
    end

    always_ff @(posedge tck) begin
        if (byte_valid && !is_end) begin
            coords <= coord_next;
        end
    end

    always_ff @(posedge tck) begin
        if (byte_valid && is_end) begin
            instr.op <= (byte_data == 8'h04) ? noop : op;
            instr.x0 <= coord_next[0];
            instr.y0 <= coord_next[1];
            instr.x1 <= coord_next[2];
            instr.y1 <= coord_next[3];
            instr.last <= byte_data == 8'h04;
            instr.malformed <= (byte_data == 8'h0a)
                && ((cnt_next != 3'd4) || !op_seen || bad_range);
        end
    end

endmodule

`default_nettype wire

// File: tap_decoder.sv
`default_nettype none
`include "user_logic_settings.svh"

module tap_decoder import jtag_pkg::*; (
    input  wire logic       tck,
    input  wire tap_state_t tap,
    input  wire logic       tdi,
    output logic            byte_valid,
    output inbound_byte_t   byte_data
);

    localparam int skip_w = $clog2(`UPSTREAM_BYPASS_BITS + 2);

    logic              reset;
    logic [skip_w-1:0] skip_cnt;
    logic [2:0]        bit_cnt;
    logic              take_bit;

    assign reset = tap.test_logic_reset || !tap.ir_is_user;

    // Bits after the bypass prefix belong to our data
    assign take_bit = tap.shift_dr && (skip_cnt == skip_w'(`UPSTREAM_BYPASS_BITS));

    always_ff @(posedge tck) begin
        if (reset || tap.update_dr) begin
            skip_cnt <= '0;
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= take_bit && (bit_cnt == 3'd7);
            if (tap.shift_dr && !take_bit) begin
                skip_cnt <= skip_cnt + 1'b1;
            end
            if (take_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge tck) begin
        if (take_bit) begin
            byte_data <= {tdi, byte_data[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: lights_pkg.sv
`default_nettype none

package lights_pkg;

    typedef enum logic [1:0] {
        noop,
        turn_on,
        turn_off,
        toggle
    } light_op_t;

    typedef logic [11:0] coord_t;

    // One normalized line of the input file
    typedef struct packed {
        light_op_t op;
        coord_t    x0;
        coord_t    y0;
        coord_t    x1;
        coord_t    y1;
        logic      last;
        logic      malformed;
    } light_instr_t;

    // Number of lit lights
    typedef logic [23:0] result_t;

endpackage

`default_nettype wire

// File: jtag_pkg.sv
`default_nettype none

package jtag_pkg;

    // Strobes from the TAP controller
    typedef struct packed {
        logic test_logic_reset;
        logic ir_is_user;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
    } tap_state_t;

    typedef logic [7:0] inbound_byte_t;

endpackage

`default_nettype wire

// File: user_logic_settings.svh
`ifndef USER_LOGIC_SETTINGS_SVH
`define USER_LOGIC_SETTINGS_SVH

// Lights per row and number of rows
`define LIGHT_GRID_SIZE 16

// Bypassed device ahead of us in the scan chain
`define UPSTREAM_BYPASS_BITS 1

// Power of two
`define INSTR_FIFO_DEPTH 16

`define CDC_SYNC_STAGES 3

`endif
